//--- verilog/lwe_pkg.sv
package lwe_pkg;

   // datapath widths, all arithmetic wraps mod 2^DATA_W
   localparam int DATA_W = 32;
   localparam int S_W    = 2;   // secret elements are small

   // message bit lands at this bit position of b
   localparam int DELTA_SHIFT = 6;

   // default matrix size for the top level
   localparam int DEF_N_ROWS = 4;
   localparam int DEF_K_COLS = 8;

   // element types held in the operand memories
   typedef logic [DATA_W-1:0] word_t;   // A entries and b results
   typedef logic [S_W-1:0]    secret_t;
   typedef logic              msg_t;    // one message bit per row

endpackage

//--- verilog/link_pkg.sv
package link_pkg;

   // byte stream on both the load and the dump side
   localparam int BYTE_W = 8;
   localparam int LANES  = 4;   // bytes per word, little endian

   // which byte of a word is being handled
   typedef logic [1:0] lane_t;

   // top level phases of one encryption run
   typedef enum logic [1:0] {
      IDLE,      // waiting for start
      COMPUTE,   // matrix walk in progress
      DRAIN,     // last rows still in the pipe
      DUMP       // results going out byte by byte
   } phase_t;

endpackage

//--- verilog/word_packer.sv
`timescale 1ns/100ps

module word_packer #(
   parameter int ADDR_W = 6
) (
   input  logic                        clk_100mhz,
   input  logic                        sys_rst,
   input  logic [link_pkg::BYTE_W-1:0] rx_byte,
   input  logic                        rx_valid,
   output lwe_pkg::word_t              word,
   output logic [ADDR_W-1:0]           word_addr,
   output logic                        word_valid
);
   import link_pkg::*;

   localparam int LOW_W = (LANES - 1) * BYTE_W;

   lane_t             lane;
   logic [LOW_W-1:0]  low_bytes;   // first three bytes of the group
   logic [ADDR_W-1:0] next_addr;
   logic              last_lane;

   assign last_lane = (lane == lane_t'(LANES - 1));

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         lane       <= '0;
         next_addr  <= '0;
         word_addr  <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= 1'b0;
         if (rx_valid) begin
            lane <= last_lane ? '0 : lane + 1'b1;
            if (last_lane) begin
               word_valid <= 1'b1;
               word_addr  <= next_addr;
               // stick at all ones, past the last region
               if (next_addr != '1)
                  next_addr <= next_addr + 1'b1;
            end
         end
      end
   end

   // new bytes enter at the top, so byte 0 ends up in the low lane
   always_ff @(posedge clk_100mhz) begin
      if (rx_valid) begin
         low_bytes <= {rx_byte, low_bytes[LOW_W-1:BYTE_W]};
         if (last_lane)
            word <= {rx_byte, low_bytes};
      end
   end

endmodule

//--- verilog/operand_ram.sv
`timescale 1ns/100ps

module operand_ram #(
   parameter int  DEPTH  = 16,
   parameter type elem_t = logic,
   localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic          clk_100mhz,
   input  logic          wr_en,
   input  logic [AW-1:0] wr_addr,
   input  elem_t         wr_data,
   input  logic [AW-1:0] rd_addr,
   output elem_t         rd_data
);

   elem_t mem [DEPTH];

   // write port, fed from the loader or the mac
   always_ff @(posedge clk_100mhz) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk_100mhz) begin
      rd_data <= mem[rd_addr];
   end

endmodule

//--- verilog/index_counter.sv
`timescale 1ns/100ps

module index_counter #(
   parameter int  N_ROWS = 4,
   parameter int  K_COLS = 8,
   localparam int ROW_W  = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
   localparam int COL_W  = (K_COLS > 1) ? $clog2(K_COLS) : 1
) (
   input  logic             clk_100mhz,
   input  logic             sys_rst,
   input  logic             run,
   output logic [ROW_W-1:0] row,
   output logic [COL_W-1:0] col,
   output logic             idx_valid,
   output logic             row_last,
   output logic             walk_done
);

   logic active;
   logic col_end;
   logic row_end;

   assign col_end   = (col == COL_W'(K_COLS - 1));
   assign row_end   = (row == ROW_W'(N_ROWS - 1));
   assign idx_valid = active;
   assign row_last  = active && col_end;   // marks the last column of a row

   // col runs fastest, one pair per cycle
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         active    <= 1'b0;
         row       <= '0;
         col       <= '0;
         walk_done <= 1'b0;
      end else begin
         walk_done <= 1'b0;
         if (run) begin
            active <= 1'b1;
            row    <= '0;
            col    <= '0;
         end else if (active) begin
            if (col_end) begin
               col <= '0;
               if (row_end) begin
                  active    <= 1'b0;
                  walk_done <= 1'b1;   // cycle after the final pair
               end else begin
                  row <= row + 1'b1;
               end
            end else begin
               col <= col + 1'b1;
            end
         end
      end
   end

endmodule

//--- verilog/lwe_control.sv
`timescale 1ns/100ps

module lwe_control #(
   parameter int N_ROWS = 4,
   parameter int K_COLS = 8
) (
   input  logic clk_100mhz,
   input  logic sys_rst,
   input  logic start,
   input  logic walk_done,
   input  logic dump_done,
   output logic run,
   output logic dump_start,
   output logic running,
   output logic done
);
   import link_pkg::*;

   localparam int DRAIN_CYCLES = 3;   // ram read, mac register, b write

   phase_t     phase;
   logic [1:0] drain_cnt;

   assign running = (phase != IDLE);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         phase      <= IDLE;
         run        <= 1'b0;
         dump_start <= 1'b0;
         done       <= 1'b0;
         drain_cnt  <= '0;
      end else begin
         run        <= 1'b0;
         dump_start <= 1'b0;
         done       <= 1'b0;
         case (phase)
            IDLE: begin
               if (start) begin   // start only counts here
                  phase <= COMPUTE;
                  run   <= 1'b1;
               end
            end
            COMPUTE: begin
               if (walk_done) begin
                  phase     <= DRAIN;
                  drain_cnt <= '0;
               end
            end
            DRAIN: begin
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
                  phase      <= DUMP;
                  dump_start <= 1'b1;
               end
            end
            DUMP: begin
               if (dump_done) begin
                  phase <= IDLE;
                  done  <= 1'b1;
               end
            end
            default: phase <= IDLE;
         endcase
      end
   end

endmodule

//--- verilog/mac_row.sv
`timescale 1ns/100ps

module mac_row #(
   parameter int ROW_W = 2
) (
   input  logic               clk_100mhz,
   input  logic               sys_rst,
   input  logic               in_valid,
   input  logic               in_row_last,
   input  logic [ROW_W-1:0]   in_row,
   input  lwe_pkg::word_t     a_elem,
   input  lwe_pkg::secret_t   s_elem,
   input  lwe_pkg::msg_t      m_bit,
   output logic               b_valid,
   output lwe_pkg::word_t     b_word,
   output logic [ROW_W-1:0]   b_row
);
   import lwe_pkg::*;

   word_t acc;        // running sum of the current row
   word_t prod;
   word_t msg_term;
   word_t row_sum;

   // low DATA_W bits only, everything wraps
   assign prod     = a_elem * word_t'(s_elem);
   assign msg_term = word_t'(m_bit) << DELTA_SHIFT;
   assign row_sum  = acc + prod + msg_term;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         acc     <= '0;
         b_valid <= 1'b0;
      end else begin
         b_valid <= 1'b0;
         if (in_valid) begin
            if (in_row_last) begin
               b_valid <= 1'b1;
               acc     <= '0;   // next row may start right away
            end else begin
               acc <= acc + prod;
            end
         end
      end
   end

   // finished row with its index
   always_ff @(posedge clk_100mhz) begin
      if (in_valid && in_row_last) begin
         b_word <= row_sum;
         b_row  <= in_row;
      end
   end

endmodule

//--- verilog/byte_serializer.sv
`timescale 1ns/100ps

module byte_serializer #(
   parameter int  DEPTH = 4,
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic                        clk_100mhz,
   input  logic                        sys_rst,
   input  logic                        dump_start,
   input  logic                        tx_busy,
   output logic [AW-1:0]               rd_addr,
   input  lwe_pkg::word_t              rd_data,
   output logic [link_pkg::BYTE_W-1:0] tx_byte,
   output logic                        tx_trigger,
   output logic                        dump_done
);
   import link_pkg::*;

   lane_t lane;
   logic  active;
   logic  fetch_wait;   // rd_data not yet valid for rd_addr
   logic  finishing;    // last byte is on the wire
   logic  can_send;
   logic  word_end;
   logic  mem_end;

   // never two triggers back to back, tx_busy only rises a cycle later
   assign can_send = active && !fetch_wait && !tx_busy && !tx_trigger;
   assign word_end = (lane == lane_t'(LANES - 1));
   assign mem_end  = (rd_addr == AW'(DEPTH - 1));

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         lane       <= '0;
         active     <= 1'b0;
         fetch_wait <= 1'b0;
         finishing  <= 1'b0;
         rd_addr    <= '0;
         tx_trigger <= 1'b0;
         dump_done  <= 1'b0;
      end else begin
         tx_trigger <= 1'b0;
         fetch_wait <= 1'b0;
         finishing  <= 1'b0;
         dump_done  <= finishing;
         if (dump_start) begin
            active     <= 1'b1;
            rd_addr    <= '0;
            lane       <= '0;
            fetch_wait <= 1'b1;
         end else if (can_send) begin
            tx_trigger <= 1'b1;
            lane       <= word_end ? '0 : lane + 1'b1;
            if (word_end) begin
               if (mem_end) begin
                  active    <= 1'b0;
                  finishing <= 1'b1;
               end else begin
                  rd_addr    <= rd_addr + 1'b1;
                  fetch_wait <= 1'b1;
               end
            end
         end
      end
   end

   // byte goes out with its trigger, lowest lane first
   always_ff @(posedge clk_100mhz) begin
      if (can_send)
         tx_byte <= rd_data[lane*BYTE_W +: BYTE_W];
   end

endmodule

//--- verilog/lwe_top.sv
`timescale 1ns/100ps

module lwe_top #(
   parameter int N_ROWS = lwe_pkg::DEF_N_ROWS,
   parameter int K_COLS = lwe_pkg::DEF_K_COLS
) (
   input  logic                        clk_100mhz,
   input  logic                        sys_rst,
   input  logic [link_pkg::BYTE_W-1:0] rx_byte,
   input  logic                        rx_valid,
   input  logic                        start,
   input  logic                        tx_busy,
   output logic [link_pkg::BYTE_W-1:0] tx_byte,
   output logic                        tx_trigger,
   output logic                        running,
   output logic                        done
);
   import lwe_pkg::*;

   // load map is A, then s, then m
   localparam int A_WORDS  = N_ROWS * K_COLS;
   localparam int S_BASE   = A_WORDS;
   localparam int M_BASE   = A_WORDS + K_COLS;
   localparam int LOAD_END = M_BASE + N_ROWS;
   localparam int LOAD_W   = $clog2(LOAD_END + 1);   // saturated address is unused
   localparam int ROW_W    = (N_ROWS > 1) ? $clog2(N_ROWS) : 1;
   localparam int COL_W    = (K_COLS > 1) ? $clog2(K_COLS) : 1;
   localparam int A_AW     = (A_WORDS > 1) ? $clog2(A_WORDS) : 1;

   word_t             word;
   logic [LOAD_W-1:0] word_addr;
   logic              word_valid;
   logic              a_we;
   logic              s_we;
   logic              m_we;
   logic [A_AW-1:0]   a_wr_addr;
   logic [COL_W-1:0]  s_wr_addr;
   logic [ROW_W-1:0]  m_wr_addr;

   logic              run;
   logic              walk_done;
   logic              idx_valid;
   logic              row_last;
   logic [ROW_W-1:0]  row;
   logic [COL_W-1:0]  col;
   logic [A_AW-1:0]   a_rd_addr;
   word_t             a_rd;
   secret_t           s_rd;
   msg_t              m_rd;
   logic              idx_valid_q;
   logic              row_last_q;
   logic [ROW_W-1:0]  row_q;
   logic              b_valid;
   word_t             b_word;
   logic [ROW_W-1:0]  b_row;

   logic              dump_start;
   logic              dump_done;
   logic [ROW_W-1:0]  b_rd_addr;
   word_t             b_rd;

   word_packer #(.ADDR_W(LOAD_W)) packer (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .rx_byte    (rx_byte),
      .rx_valid   (rx_valid),
      .word       (word),
      .word_addr  (word_addr),
      .word_valid (word_valid)
   );

   // region decode, words past m fall through
   assign a_we = word_valid && (word_addr < LOAD_W'(S_BASE));
   assign s_we = word_valid && (word_addr >= LOAD_W'(S_BASE)) && (word_addr < LOAD_W'(M_BASE));
   assign m_we = word_valid && (word_addr >= LOAD_W'(M_BASE)) && (word_addr < LOAD_W'(LOAD_END));
   assign a_wr_addr = A_AW'(word_addr);
   assign s_wr_addr = COL_W'(word_addr - LOAD_W'(S_BASE));
   assign m_wr_addr = ROW_W'(word_addr - LOAD_W'(M_BASE));
   assign a_rd_addr = A_AW'(row * K_COLS + col);   // row major

   operand_ram #(.DEPTH(A_WORDS), .elem_t(word_t)) a_ram (
      .clk_100mhz (clk_100mhz),
      .wr_en      (a_we),
      .wr_addr    (a_wr_addr),
      .wr_data    (word),
      .rd_addr    (a_rd_addr),
      .rd_data    (a_rd)
   );

   operand_ram #(.DEPTH(K_COLS), .elem_t(secret_t)) s_ram (
      .clk_100mhz (clk_100mhz),
      .wr_en      (s_we),
      .wr_addr    (s_wr_addr),
      .wr_data    (word[S_W-1:0]),   // low bits only
      .rd_addr    (col),
      .rd_data    (s_rd)
   );

   operand_ram #(.DEPTH(N_ROWS), .elem_t(msg_t)) m_ram (
      .clk_100mhz (clk_100mhz),
      .wr_en      (m_we),
      .wr_addr    (m_wr_addr),
      .wr_data    (word[0]),
      .rd_addr    (row),
      .rd_data    (m_rd)
   );

   index_counter #(.N_ROWS(N_ROWS), .K_COLS(K_COLS)) walker (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .run        (run),
      .row        (row),
      .col        (col),
      .idx_valid  (idx_valid),
      .row_last   (row_last),
      .walk_done  (walk_done)
   );

   // line the index flags up with the ram outputs
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         idx_valid_q <= 1'b0;
         row_last_q  <= 1'b0;
      end else begin
         idx_valid_q <= idx_valid;
         row_last_q  <= row_last;
      end
   end

   always_ff @(posedge clk_100mhz) begin
      row_q <= row;
   end

   mac_row #(.ROW_W(ROW_W)) mac (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .in_valid    (idx_valid_q),
      .in_row_last (row_last_q),
      .in_row      (row_q),
      .a_elem      (a_rd),
      .s_elem      (s_rd),
      .m_bit       (m_rd),
      .b_valid     (b_valid),
      .b_word      (b_word),
      .b_row       (b_row)
   );

   operand_ram #(.DEPTH(N_ROWS), .elem_t(word_t)) b_ram (
      .clk_100mhz (clk_100mhz),
      .wr_en      (b_valid),
      .wr_addr    (b_row),
      .wr_data    (b_word),
      .rd_addr    (b_rd_addr),
      .rd_data    (b_rd)
   );

   lwe_control #(.N_ROWS(N_ROWS), .K_COLS(K_COLS)) ctrl (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .start      (start),
      .walk_done  (walk_done),
      .dump_done  (dump_done),
      .run        (run),
      .dump_start (dump_start),
      .running    (running),
      .done       (done)
   );

   byte_serializer #(.DEPTH(N_ROWS)) serializer (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .dump_start (dump_start),
      .tx_busy    (tx_busy),
      .rd_addr    (b_rd_addr),
      .rd_data    (b_rd),
      .tx_byte    (tx_byte),
      .tx_trigger (tx_trigger),
      .dump_done  (dump_done)
   );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
   parameter int HALF_NS    = 5,   // 10 ns period
   parameter int RST_CYCLES = 2
) (
   output logic clk_100mhz,
   output logic por_rst
);

   initial begin
      clk_100mhz = 1'b0;
      forever #HALF_NS clk_100mhz = ~clk_100mhz;
   end

   // power-on reset over the first rising edges
   initial begin
      por_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_100mhz);
      por_rst <= 1'b0;
   end

endmodule

//--- verif/tb_lwe.sv
`timescale 1ns/100ps

module tb_lwe;
   import lwe_pkg::*;
   import link_pkg::*;

   localparam int N            = 4;
   localparam int K            = 8;
   localparam int NUM_CASES    = 3;
   localparam int RUNS         = 2;   // second run reuses the loaded operands
   localparam int LOAD_BYTES   = LANES * (N * K + K + N);
   localparam int CASE_LEN     = LOAD_BYTES + N;
   localparam int EXTRA_BYTES  = 8;   // land past the m region
   localparam int MAX_BUSY     = 6;
   localparam int RUN_LIMIT    = N * K + LANES * N * (MAX_BUSY + 2) + 40;
   localparam int LIMIT_CYCLES = NUM_CASES * (LOAD_BYTES + EXTRA_BYTES
                                 + RUNS * (N * K + LANES * N * 8 + 20)) + 200;

   logic              clk_100mhz;
   logic              por_rst;
   logic              case_rst;
   logic              sys_rst;
   logic [BYTE_W-1:0] rx_byte;
   logic              rx_valid;
   logic              start;
   logic              tx_busy;
   logic [BYTE_W-1:0] tx_byte;
   logic              tx_trigger;
   logic              running;
   logic              done;

   word_t             pat [NUM_CASES * CASE_LEN];
   logic [BYTE_W-1:0] byte_q [$];   // bytes seen on the tx side
   int                done_count;
   int                busy_left;
   logic              trig_q;
   integer            seed;
   int                case_idx;
   int                run_idx;

   assign sys_rst = por_rst | case_rst;

   tb_clock clk_gen (
      .clk_100mhz (clk_100mhz),
      .por_rst    (por_rst)
   );

   lwe_top #(.N_ROWS(N), .K_COLS(K)) uut (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .rx_byte    (rx_byte),
      .rx_valid   (rx_valid),
      .start      (start),
      .tx_busy    (tx_busy),
      .tx_byte    (tx_byte),
      .tx_trigger (tx_trigger),
      .running    (running),
      .done       (done)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      assert (actual === expected)
      else stop_run($sformatf("FAIL at %0t ns: %s expected %h, got %h",
                              $time, name, expected, actual));
   endtask

   task automatic apply_reset();
      @(posedge clk_100mhz);
      case_rst <= 1'b1;
      repeat (2) @(posedge clk_100mhz);
      case_rst <= 1'b0;
      byte_q.delete();
      @(posedge clk_100mhz);
      check_value("tx_trigger", 32'd0, tx_trigger);
      check_value("running", 32'd0, running);
      check_value("done", 32'd0, done);
   endtask

   task automatic load_operands(input int base);
      int     i;
      integer rnd;
      for (i = 0; i < LOAD_BYTES; i++) begin
         @(posedge clk_100mhz);
         rx_byte  <= pat[base + i][BYTE_W-1:0];
         rx_valid <= 1'b1;
      end
      for (i = 0; i < EXTRA_BYTES; i++) begin
         @(posedge clk_100mhz);
         rnd = $random(seed);
         rx_byte <= rnd[BYTE_W-1:0];   // junk after m
      end
      @(posedge clk_100mhz);
      rx_valid <= 1'b0;
      repeat (3) @(posedge clk_100mhz);
      check_value("tx byte count before start", 32'd0, byte_q.size());
   endtask

   task automatic run_and_check(input int exp_base, input int run_no);
      int    cycles;
      int    n;
      int    l;
      logic  finished;
      word_t got;
      done_count = 0;
      byte_q.delete();
      @(posedge clk_100mhz);
      start <= 1'b1;
      @(posedge clk_100mhz);
      start <= 1'b0;
      @(posedge clk_100mhz);
      check_value("running", 32'd1, running);
      cycles   = 0;
      finished = 1'b0;
      while (!finished) begin
         @(posedge clk_100mhz);
         cycles++;
         // stray starts during compute and during the dump
         start    <= (cycles == 10) || (cycles == N * K + 20);
         finished = done;
         assert (cycles < RUN_LIMIT)
         else stop_run($sformatf("no done pulse within %0d cycles of start", RUN_LIMIT));
      end
      start <= 1'b0;
      check_value("running", 32'd0, running);
      repeat (10) @(posedge clk_100mhz);   // room for stray bytes or pulses
      check_value("done pulse count", 32'd1, done_count);
      check_value("tx byte count", LANES * N, byte_q.size());
      for (n = 0; n < N; n++) begin
         for (l = 0; l < LANES; l++)
            got[l*BYTE_W +: BYTE_W] = byte_q[n * LANES + l];   // lsb first
         check_value($sformatf("b[%0d] run %0d", n, run_no), pat[exp_base + n], got);
      end
   endtask

   // transmitter model with a random busy hold
   always @(posedge clk_100mhz) begin
      if (sys_rst) begin
         tx_busy   <= 1'b0;
         busy_left = 0;
         trig_q    = 1'b0;
      end else begin
         if (tx_trigger) begin
            assert (!tx_busy)
            else stop_run($sformatf("tx_trigger at %0t ns while tx_busy was high", $time));
            assert (!trig_q)
            else stop_run($sformatf("tx_trigger high two cycles in a row at %0t ns", $time));
            byte_q.push_back(tx_byte);
            tx_busy   <= 1'b1;
            busy_left = {$random(seed)} % MAX_BUSY;   // 0 to 5 extra cycles
         end else if (busy_left != 0) begin
            busy_left--;
         end else begin
            tx_busy <= 1'b0;
         end
         if (done)
            done_count++;
         trig_q = tx_trigger;
      end
   end

   initial begin
      seed       = 32'hff1e06ba;
      case_rst   = 1'b0;
      rx_byte    = '0;
      rx_valid   = 1'b0;
      start      = 1'b0;
      tx_busy    = 1'b0;
      done_count = 0;
      busy_left  = 0;
      trig_q     = 1'b0;
      $readmemh("verif/lwe_patterns.txt", pat);
      assert (pat[NUM_CASES * CASE_LEN - 1] !== 'x)
      else stop_run("pattern file verif/lwe_patterns.txt is missing or too short");
      @(posedge clk_100mhz);
      while (por_rst)
         @(posedge clk_100mhz);
      for (case_idx = 0; case_idx < NUM_CASES; case_idx++) begin
         apply_reset();
         load_operands(case_idx * CASE_LEN);
         for (run_idx = 0; run_idx < RUNS; run_idx++)
            run_and_check(case_idx * CASE_LEN + LOAD_BYTES, run_idx);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk_100mhz);
      stop_run($sformatf("timeout, the tests did not finish within %0d cycles", LIMIT_CYCLES));
   end

endmodule

//--- verif/lwe_patterns.txt
// per case 176 load bytes, one hex byte per token, words lsb first: 4 A rows, then s, then m
// then the 4 expected b words, row 0 first
// case 0: small counting matrix
01 00 00 00 02 00 00 00 03 00 00 00 04 00 00 00 05 00 00 00 06 00 00 00 07 00 00 00 08 00 00 00
09 00 00 00 0a 00 00 00 0b 00 00 00 0c 00 00 00 0d 00 00 00 0e 00 00 00 0f 00 00 00 10 00 00 00
11 00 00 00 12 00 00 00 13 00 00 00 14 00 00 00 15 00 00 00 16 00 00 00 17 00 00 00 18 00 00 00
19 00 00 00 1a 00 00 00 1b 00 00 00 1c 00 00 00 1d 00 00 00 1e 00 00 00 1f 00 00 00 20 00 00 00
01 00 00 00 02 00 00 00 03 00 00 00 00 00 00 00 01 00 00 00 02 00 00 00 03 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 01 00 00 00 00 00 00 00
00000074 00000094 00000134 00000154
// case 1: full width A with wrap, s and m words with upper bits set
ef be ad de ef be ad de ef be ad de ef be ad de ef be ad de ef be ad de ef be ad de ef be ad de
78 56 34 12 78 56 34 12 78 56 34 12 78 56 34 12 78 56 34 12 78 56 34 12 78 56 34 12 78 56 34 12
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
01 00 00 80 01 00 00 80 01 00 00 80 01 00 00 80 01 00 00 80 01 00 00 80 01 00 00 80 01 00 00 80
ff ff ff ff 05 00 00 00 a6 a5 a5 a5 fc ff ff 7f 03 01 00 00 01 ff 00 00 fe ff ff ff 79 56 34 12
fe ff ff ff 03 00 00 00 00 00 00 80 ff ff ff ff
4ed2b223 eca86458 fffffff3 8000004d
// case 2: zero matrix, message term only
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
01 00 00 00 11 00 00 00 01 ff ff ff 01 01 00 00
00000040 00000040 00000040 00000040

//--- filelist.f
verilog/lwe_pkg.sv
verilog/link_pkg.sv
verilog/word_packer.sv
verilog/operand_ram.sv
verilog/index_counter.sv
verilog/lwe_control.sv
verilog/mac_row.sv
verilog/byte_serializer.sv
verilog/lwe_top.sv
verif/tb_clock.sv
verif/tb_lwe.sv

//--- Bender.yml
package:
  name: lwe_engine

sources:
  - verilog/lwe_pkg.sv
  - verilog/link_pkg.sv
  - verilog/word_packer.sv
  - verilog/operand_ram.sv
  - verilog/index_counter.sv
  - verilog/lwe_control.sv
  - verilog/mac_row.sv
  - verilog/byte_serializer.sv
  - verilog/lwe_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_lwe.sv
